// File: dv/core_demux_tb.sv
`timescale 1ns/100ps

module core_demux_tb;

  localparam int DATA_WIDTH = 32;
  localparam int BE_W       = DATA_WIDTH / 8;
  localparam int AW         = core_demux_pkg::ADDR_W;
  localparam int N_TESTS    = 6;

  logic clk = 1'b0;
  logic rst_ni;
  logic [core_demux_pkg::CLUSTER_ID_W-1:0] cluster_id_i;

  // Core port
  logic                  core_req_i;
  logic                  core_wen_i;
  logic [AW-1:0]         core_addr_i;
  logic [DATA_WIDTH-1:0] core_wdata_i;
  logic [BE_W-1:0]       core_be_i;
  logic                  core_gnt_o;
  logic                  core_r_valid_o;
  logic [DATA_WIDTH-1:0] core_r_rdata_o;
  logic                  core_r_opc_o;

  // Target ports on the request side
  logic                  sh_req_o, ext_req_o, pe_req_o;
  logic                  sh_wen_o, ext_wen_o, pe_wen_o;
  logic [AW-1:0]         sh_addr_o, ext_addr_o, pe_addr_o;
  logic [DATA_WIDTH-1:0] sh_wdata_o, ext_wdata_o, pe_wdata_o;
  logic [BE_W-1:0]       sh_be_o, ext_be_o, pe_be_o;
  logic                  sh_gnt_i, ext_gnt_i, pe_gnt_i;

  // Target response ports driven by the models below
  logic                  sh_r_valid_i  = 1'b0;
  logic                  ext_r_valid_i = 1'b0;
  logic                  pe_r_valid_i  = 1'b0;
  logic [DATA_WIDTH-1:0] sh_r_rdata_i  = '0;
  logic [DATA_WIDTH-1:0] ext_r_rdata_i = '0;
  logic [DATA_WIDTH-1:0] pe_r_rdata_i  = '0;
  logic                  ext_r_opc_i   = 1'b0;
  logic                  pe_r_opc_i    = 1'b0;

  logic perf_l2_ld_o, perf_l2_st_o, perf_l2_ld_cyc_o, perf_l2_st_cyc_o;

  int unsigned errors = 0;
  int unsigned checks = 0;
  int unsigned cyc    = 0;    // Rising edges since start

  // Expected core response for the cycle after a grant
  logic                  rsp_pend = 1'b0;
  logic [DATA_WIDTH-1:0] rsp_data;
  logic                  rsp_opc;

  core_demux #(.DATA_WIDTH(DATA_WIDTH)) dut_i (.*);

  always #5 clk = ~clk;
  always @(posedge clk) cyc <= cyc + 1;

  // ****************************************
  // Compare tasks and reference rules
  // ****************************************

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] got,
                            input logic [DATA_WIDTH-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_addr(input string name, input logic [AW-1:0] got,
                            input logic [AW-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_dest(input string name, input core_demux_pkg::dest_e got,
                            input core_demux_pkg::dest_e exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("ERROR: %s at %0t", what, $time);
  endtask

  // Cluster 3 owns regions 0x10C to 0x10F
  function automatic core_demux_pkg::dest_e dest_of(input logic [AW-1:0] addr);
    if (addr[31:20] == 12'h10C || addr[31:20] == 12'h10D)
      return core_demux_pkg::DEST_SH;
    if (addr[31:20] == 12'h10E && addr[14])
      return core_demux_pkg::DEST_EXT;
    return core_demux_pkg::DEST_PE;
  endfunction

  // Each target answers with its own pattern over the address
  function automatic logic [DATA_WIDTH-1:0] rsp_word(input logic [7:0] tag,
                                                     input logic [AW-1:0] addr);
    return DATA_WIDTH'(addr ^ {4{tag}});
  endfunction

  function automatic logic [7:0] dest_tag(input core_demux_pkg::dest_e dest);
    case (dest)
      core_demux_pkg::DEST_SH:  return 8'h5A;
      core_demux_pkg::DEST_EXT: return 8'hE1;
      default:                  return 8'h3C;
    endcase
  endfunction

  // ****************************************
  // Target models
  // ****************************************

  int unsigned   lcg_q    = 20458;
  int unsigned   max_wait = 2;    // Longest withheld grant or response
  int unsigned   sh_wait  = 0;
  int unsigned   ext_wait = 0;
  int unsigned   pe_wait  = 0;
  int unsigned   pe_rsp_wait;
  int unsigned   pe_takes   = 0;  // Requests accepted by PE
  int unsigned   pe_rsp_cyc = 0;  // Cycle of the last PE response
  logic          sh_take, ext_take, pe_take;
  logic          sh_pend, ext_pend, pe_pend;
  logic          pe_busy = 1'b0;
  logic [AW-1:0] sh_addr_c, ext_addr_c;
  logic [AW-1:0] pe_addr_c;
  logic          pe_wen_c;
  logic [DATA_WIDTH-1:0] pe_wdata_c;
  logic [BE_W-1:0]       pe_be_c;

  function automatic int unsigned draw_delay();
    lcg_q = lcg_q * 32'd1103515245 + 32'd12345;
    return (lcg_q >> 16) % (max_wait + 1);
  endfunction

  // Grant as soon as the withheld count runs out
  assign sh_gnt_i  = sh_req_o && (sh_wait == 0);
  assign ext_gnt_i = ext_req_o && (ext_wait == 0);
  assign pe_gnt_i  = pe_req_o && (pe_wait == 0);

  always
  begin
    @(negedge clk);
    sh_pend    = sh_req_o;
    ext_pend   = ext_req_o;
    pe_pend    = pe_req_o;
    sh_take    = sh_req_o && sh_gnt_i;
    ext_take   = ext_req_o && ext_gnt_i;
    pe_take    = pe_req_o && pe_gnt_i;
    sh_addr_c  = sh_addr_o;
    ext_addr_c = ext_addr_o;
    if (pe_req_o && pe_busy)
      report_error("second PE request issued before the first response");
    if (pe_take)
    begin
      pe_takes++;
      pe_addr_c  = pe_addr_o;
      pe_wen_c   = pe_wen_o;
      pe_wdata_c = pe_wdata_o;
      pe_be_c    = pe_be_o;
    end
    if (pe_r_valid_i)
      pe_rsp_cyc = cyc;
    @(posedge clk);
    #1;
    // SH and EXT answer the cycle after their grant
    sh_r_valid_i  = sh_take;
    sh_r_rdata_i  = rsp_word(8'h5A, sh_addr_c);
    ext_r_valid_i = ext_take;
    ext_r_rdata_i = rsp_word(8'hE1, ext_addr_c);
    ext_r_opc_i   = ext_addr_c[3];
    if (sh_take)
      sh_wait = draw_delay();
    else if (sh_pend && sh_wait != 0)
      sh_wait--;
    if (ext_take)
      ext_wait = draw_delay();
    else if (ext_pend && ext_wait != 0)
      ext_wait--;
    // PE answers a random number of cycles after its grant
    pe_r_valid_i = 1'b0;
    if (pe_take)
    begin
      pe_busy     = 1'b1;
      pe_rsp_wait = draw_delay();
      pe_wait     = draw_delay();
    end
    else if (pe_busy)
    begin
      if (pe_rsp_wait == 0)
      begin
        pe_r_valid_i = 1'b1;
        pe_r_rdata_i = rsp_word(8'h3C, pe_addr_c);
        pe_r_opc_i   = pe_addr_c[3];
        pe_busy      = 1'b0;
      end
      else
        pe_rsp_wait--;
    end
    else if (pe_pend && pe_wait != 0)
      pe_wait--;
  end

  // ****************************************
  // Core-side driver
  // ****************************************

  task automatic check_response();
    check_bit("core_r_valid_o", core_r_valid_o, rsp_pend);
    if (rsp_pend)
    begin
      check_data("core_r_rdata_o", core_r_rdata_o, rsp_data);
      check_bit("core_r_opc_o", core_r_opc_o, rsp_opc);
    end
    rsp_pend = 1'b0;
  endtask

  // One request held until granted; its response is checked next cycle
  task automatic transfer(input logic [AW-1:0] addr, input logic wen);
    core_demux_pkg::dest_e exp_dest;
    core_demux_pkg::dest_e seen;
    logic [DATA_WIDTH-1:0] wdata;
    logic [BE_W-1:0]       be;
    logic                  l2;
    logic                  exp_gnt;
    int unsigned           takes_before;
    exp_dest     = dest_of(addr);
    wdata        = DATA_WIDTH'(~addr);
    be           = BE_W'(addr >> 4);
    l2           = (exp_dest != core_demux_pkg::DEST_SH);
    takes_before = pe_takes;
    @(posedge clk);
    #1;
    core_req_i   = 1'b1;
    core_addr_i  = addr;
    core_wen_i   = wen;
    core_wdata_i = wdata;
    core_be_i    = be;
    do
    begin
      @(negedge clk);
      check_response();
      // SH and EXT grant once their model stops withholding
      if (exp_dest == core_demux_pkg::DEST_SH)
        exp_gnt = (sh_wait == 0);
      else if (exp_dest == core_demux_pkg::DEST_EXT)
        exp_gnt = (ext_wait == 0);
      else
        exp_gnt = (cyc == pe_rsp_cyc + 1);  // One cycle after the PE response
      check_bit("core_gnt_o", core_gnt_o, exp_gnt);
      check_bit("sh_req_o", sh_req_o, exp_dest == core_demux_pkg::DEST_SH);
      check_bit("ext_req_o", ext_req_o, exp_dest == core_demux_pkg::DEST_EXT);
      check_bit("perf_l2_ld_cyc_o", perf_l2_ld_cyc_o, l2 && wen);  // Every waiting cycle
      check_bit("perf_l2_st_cyc_o", perf_l2_st_cyc_o, l2 && !wen);
      check_bit("perf_l2_ld_o", perf_l2_ld_o, l2 && wen && exp_gnt);
      check_bit("perf_l2_st_o", perf_l2_st_o, l2 && !wen && exp_gnt);
    end
    while (!core_gnt_o);
    seen = sh_req_o ? core_demux_pkg::DEST_SH :
           (ext_req_o ? core_demux_pkg::DEST_EXT : core_demux_pkg::DEST_PE);
    check_dest("target", seen, exp_dest);
    if (exp_dest == core_demux_pkg::DEST_SH)
    begin
      check_addr("sh_addr_o", sh_addr_o, addr);
      check_data("sh_wdata_o", sh_wdata_o, wdata);
      check_data("sh_be_o", DATA_WIDTH'(sh_be_o), DATA_WIDTH'(be));
      check_bit("sh_wen_o", sh_wen_o, wen);
    end
    else if (exp_dest == core_demux_pkg::DEST_EXT)
    begin
      check_addr("ext_addr_o", ext_addr_o, addr);
      check_data("ext_wdata_o", ext_wdata_o, wdata);
      check_data("ext_be_o", DATA_WIDTH'(ext_be_o), DATA_WIDTH'(be));
      check_bit("ext_wen_o", ext_wen_o, wen);
    end
    else
    begin
      if (pe_takes != takes_before + 1)
        report_error("PE did not receive the request exactly once");
      check_addr("pe_addr_o", pe_addr_c, addr);
      check_data("pe_wdata_o", pe_wdata_c, wdata);
      check_data("pe_be_o", DATA_WIDTH'(pe_be_c), DATA_WIDTH'(be));
      check_bit("pe_wen_o", pe_wen_c, wen);
    end
    rsp_pend = 1'b1;
    rsp_data = rsp_word(dest_tag(exp_dest), addr);
    rsp_opc  = l2 ? addr[3] : 1'b0;   // SH has no error flag
  endtask

  task automatic idle(input int unsigned n);
    repeat (n)
    begin
      @(posedge clk);
      #1;
      core_req_i = 1'b0;
      @(negedge clk);
      check_response();
      check_bit("core_gnt_o", core_gnt_o, 1'b0);   // Grants last a single cycle
      check_bit("sh_req_o", sh_req_o, 1'b0);
      check_bit("ext_req_o", ext_req_o, 1'b0);
    end
  endtask

  // ****************************************
  // Directed tests
  // ****************************************

  task automatic test_reset();
    @(negedge clk);
    check_bit("core_gnt_o", core_gnt_o, 1'b0);
    check_bit("core_r_valid_o", core_r_valid_o, 1'b0);
    check_bit("sh_req_o", sh_req_o, 1'b0);
    check_bit("ext_req_o", ext_req_o, 1'b0);
    check_bit("pe_req_o", pe_req_o, 1'b0);
    check_bit("perf_l2_ld_o", perf_l2_ld_o, 1'b0);
    check_bit("perf_l2_st_o", perf_l2_st_o, 1'b0);
    check_bit("perf_l2_ld_cyc_o", perf_l2_ld_cyc_o, 1'b0);
    check_bit("perf_l2_st_cyc_o", perf_l2_st_cyc_o, 1'b0);
  endtask

  task automatic test_shared();
    transfer(32'h10C0_0040, 1'b1);
    idle(1);
    transfer(32'h10D0_1238, 1'b0);  // Test-and-set region
    idle(1);
  endtask

  task automatic test_ext();
    transfer(32'h10E0_4008, 1'b1);  // Error flag set by the model
    idle(1);
    transfer(32'h10E0_4100, 1'b0);
    idle(1);
  endtask

  task automatic test_pe();
    transfer(32'h10E0_0010, 1'b1);  // Peripheral region with bit 14 clear
    idle(1);
    transfer(32'h1A00_0008, 1'b0);
    idle(1);
    transfer(32'h0000_0100, 1'b1);
    idle(1);
  endtask

  task automatic test_backpressure();
    max_wait = 6;
    transfer(32'h10E0_4020, 1'b1);
    transfer(32'h10E0_402C, 1'b0);
    transfer(32'h2000_0040, 1'b1);
    transfer(32'h1A00_0108, 1'b0);
    transfer(32'h10C0_0300, 1'b1);
    idle(2);
    max_wait = 2;
  endtask

  task automatic test_mixed();
    transfer(32'h10C0_0504, 1'b1);
    transfer(32'h1A00_0508, 1'b1);
    transfer(32'h10E0_450C, 1'b1);
    transfer(32'h10D0_0510, 1'b0);
    transfer(32'h0000_0514, 1'b0);
    transfer(32'h10E0_4518, 1'b0);
    idle(2);
  endtask

  initial
  begin
    rst_ni       = 1'b0;
    cluster_id_i = 5'd3;   // SH at 0x10C/0x10D and peripherals at 0x10E
    core_req_i   = 1'b0;
    core_wen_i   = 1'b0;
    core_addr_i  = '0;
    core_wdata_i = '0;
    core_be_i    = '0;
    repeat (2) @(posedge clk);
    #1;
    rst_ni = 1'b1;
    test_reset();
    test_shared();
    test_ext();
    test_pe();
    test_backpressure();
    test_mixed();
    $display("errors: %0d of %0d checks", errors, checks);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

  // Watchdog allows 200 cycles of 10 ns per test
  initial
  begin
    #(N_TESTS * 200 * 10);
    $display("timeout: the tests did not finish within %0d cycles", N_TESTS * 200);
    $display("errors: %0d of %0d checks", errors, checks);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: project.f
rtl/core_demux_pkg.sv
rtl/req_router.sv
rtl/resp_router.sv
rtl/periph_handshake.sv
rtl/periph_req_buffer.sv
rtl/core_demux.sv
dv/core_demux_tb.sv

// File: rtl/core_demux.sv
`timescale 1ns/100ps

module core_demux #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                                    clk,
  input  logic                                    rst_ni,
  input  logic [core_demux_pkg::CLUSTER_ID_W-1:0] cluster_id_i,

  // Core side
  input  logic                                    core_req_i,
  input  logic [core_demux_pkg::ADDR_W-1:0]       core_addr_i,
  input  logic                                    core_wen_i,
  input  logic [DATA_WIDTH-1:0]                   core_wdata_i,
  input  logic [DATA_WIDTH/8-1:0]                 core_be_i,
  output logic                                    core_gnt_o,
  output logic                                    core_r_valid_o,
  output logic [DATA_WIDTH-1:0]                   core_r_rdata_o,
  output logic                                    core_r_opc_o,

  // Shared memory
  output logic                                    sh_req_o,
  output logic [core_demux_pkg::ADDR_W-1:0]       sh_addr_o,
  output logic                                    sh_wen_o,
  output logic [DATA_WIDTH-1:0]                   sh_wdata_o,
  output logic [DATA_WIDTH/8-1:0]                 sh_be_o,
  input  logic                                    sh_gnt_i,
  input  logic                                    sh_r_valid_i,
  input  logic [DATA_WIDTH-1:0]                   sh_r_rdata_i,

  // Demux peripherals
  output logic                                    ext_req_o,
  output logic [core_demux_pkg::ADDR_W-1:0]       ext_addr_o,
  output logic                                    ext_wen_o,
  output logic [DATA_WIDTH-1:0]                   ext_wdata_o,
  output logic [DATA_WIDTH/8-1:0]                 ext_be_o,
  input  logic                                    ext_gnt_i,
  input  logic                                    ext_r_valid_i,
  input  logic [DATA_WIDTH-1:0]                   ext_r_rdata_i,
  input  logic                                    ext_r_opc_i,

  // Peripheral interconnect
  output logic                                    pe_req_o,
  output logic [core_demux_pkg::ADDR_W-1:0]       pe_addr_o,
  output logic                                    pe_wen_o,
  output logic [DATA_WIDTH-1:0]                   pe_wdata_o,
  output logic [DATA_WIDTH/8-1:0]                 pe_be_o,
  input  logic                                    pe_gnt_i,
  input  logic                                    pe_r_valid_i,
  input  logic [DATA_WIDTH-1:0]                   pe_r_rdata_i,
  input  logic                                    pe_r_opc_i,

  // Performance strobes
  output logic                                    perf_l2_ld_o,
  output logic                                    perf_l2_st_o,
  output logic                                    perf_l2_ld_cyc_o,
  output logic                                    perf_l2_st_cyc_o
);

  core_demux_pkg::dest_e dest;
  logic                  pe_sel;      // Core request decoded to PE
  logic                  pe_gnt;      // Core grant from the FSM
  logic                  pe_r_valid;  // Delayed PE response
  logic [DATA_WIDTH-1:0] pe_r_rdata;
  logic                  pe_r_opc;
  logic                  buf_req;
  logic                  buf_gnt;
  logic                  buf_r_valid;
  logic [DATA_WIDTH-1:0] buf_r_rdata;
  logic                  buf_r_opc;

  // Fan-out to SH and EXT, request lines come from the router
  assign sh_addr_o   = core_addr_i;
  assign sh_wen_o    = core_wen_i;
  assign sh_wdata_o  = core_wdata_i;
  assign sh_be_o     = core_be_i;
  assign ext_addr_o  = core_addr_i;
  assign ext_wen_o   = core_wen_i;
  assign ext_wdata_o = core_wdata_i;
  assign ext_be_o    = core_be_i;

  req_router req_router_i (
    .core_req_i       (core_req_i),
    .core_addr_i      (core_addr_i),
    .core_wen_i       (core_wen_i),
    .cluster_id_i     (cluster_id_i),
    .sh_gnt_i         (sh_gnt_i),
    .ext_gnt_i        (ext_gnt_i),
    .pe_gnt_i         (pe_gnt),
    .dest_o           (dest),
    .sh_req_o         (sh_req_o),
    .ext_req_o        (ext_req_o),
    .pe_sel_o         (pe_sel),
    .core_gnt_o       (core_gnt_o),
    .perf_l2_ld_o     (perf_l2_ld_o),
    .perf_l2_st_o     (perf_l2_st_o),
    .perf_l2_ld_cyc_o (perf_l2_ld_cyc_o),
    .perf_l2_st_cyc_o (perf_l2_st_cyc_o)
  );

  resp_router #(.DATA_WIDTH(DATA_WIDTH)) resp_router_i (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .core_req_i     (core_req_i),
    .dest_i         (dest),
    .sh_r_valid_i   (sh_r_valid_i),
    .sh_r_rdata_i   (sh_r_rdata_i),
    .ext_r_valid_i  (ext_r_valid_i),
    .ext_r_rdata_i  (ext_r_rdata_i),
    .ext_r_opc_i    (ext_r_opc_i),
    .pe_r_valid_i   (pe_r_valid),
    .pe_r_rdata_i   (pe_r_rdata),
    .pe_r_opc_i     (pe_r_opc),
    .core_r_valid_o (core_r_valid_o),
    .core_r_rdata_o (core_r_rdata_o),
    .core_r_opc_o   (core_r_opc_o)
  );

  periph_handshake #(.DATA_WIDTH(DATA_WIDTH)) periph_handshake_i (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .pe_sel_i      (pe_sel),
    .buf_gnt_i     (buf_gnt),
    .buf_r_valid_i (buf_r_valid),
    .buf_r_rdata_i (buf_r_rdata),
    .buf_r_opc_i   (buf_r_opc),
    .buf_req_o     (buf_req),
    .pe_gnt_o      (pe_gnt),
    .pe_r_valid_o  (pe_r_valid),
    .pe_r_rdata_o  (pe_r_rdata),
    .pe_r_opc_o    (pe_r_opc)
  );

  periph_req_buffer #(.DATA_WIDTH(DATA_WIDTH)) periph_req_buffer_i (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .req_i        (buf_req),
    .addr_i       (core_addr_i),
    .wen_i        (core_wen_i),
    .wdata_i      (core_wdata_i),
    .be_i         (core_be_i),
    .pe_gnt_i     (pe_gnt_i),
    .pe_r_valid_i (pe_r_valid_i),
    .pe_r_rdata_i (pe_r_rdata_i),
    .pe_r_opc_i   (pe_r_opc_i),
    .gnt_o        (buf_gnt),
    .pe_req_o     (pe_req_o),
    .pe_addr_o    (pe_addr_o),
    .pe_wen_o     (pe_wen_o),
    .pe_wdata_o   (pe_wdata_o),
    .pe_be_o      (pe_be_o),
    .r_valid_o    (buf_r_valid),
    .r_rdata_o    (buf_r_rdata),
    .r_opc_o      (buf_r_opc)
  );

endmodule

// File: rtl/core_demux_pkg.sv
package core_demux_pkg;

  // ****************************************
  // Address layout
  // ****************************************

  // The map reads fixed bit positions, so the width is fixed too
  localparam int ADDR_W = 32;

  // Region field sits in the top twelve address bits
  localparam int REGION_MSB = 31;
  localparam int REGION_LSB = 20;
  localparam int REGION_W   = REGION_MSB - REGION_LSB + 1;

  // First cluster region, each cluster owns four consecutive regions
  localparam logic [REGION_W-1:0] REGION_BASE = 12'h100;

  localparam int CLUSTER_ID_W = 5;  // Up to 32 clusters

  // Inside the demux-peripheral region this bit picks EXT over PE
  localparam int EXT_SEL_BIT = 14;

  // ****************************************
  // Request targets
  // ****************************************

  typedef enum logic [1:0] {
    DEST_SH  = 2'd0,  // Cluster shared memory
    DEST_PE  = 2'd1,  // Peripheral interconnect
    DEST_EXT = 2'd2   // Demux peripherals
  } dest_e;

endpackage

// File: rtl/periph_handshake.sv
`timescale 1ns/100ps

module periph_handshake #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  logic                  pe_sel_i,       // Core request decoded to PE
  input  logic                  buf_gnt_i,
  input  logic                  buf_r_valid_i,
  input  logic [DATA_WIDTH-1:0] buf_r_rdata_i,
  input  logic                  buf_r_opc_i,
  output logic                  buf_req_o,
  output logic                  pe_gnt_o,       // Core grant for PE requests
  output logic                  pe_r_valid_o,
  output logic [DATA_WIDTH-1:0] pe_r_rdata_o,
  output logic                  pe_r_opc_o
);

  // FSM encoding
  localparam logic [1:0] TRANS_IDLE    = 2'd0;
  localparam logic [1:0] TRANS_PENDING = 2'd1;
  localparam logic [1:0] TRANS_GRANTED = 2'd2;

  logic [1:0]            state_q;
  logic [1:0]            state_d;
  logic                  rsp_valid_q;   // First delay stage
  logic [DATA_WIDTH-1:0] rsp_rdata_q;
  logic                  rsp_opc_q;

  // ****************************************
  // Transaction FSM
  // ****************************************

  always_ff @(posedge clk)
  begin
    if (!rst_ni)
    begin
      state_q <= TRANS_IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  always_comb
  begin
    state_d   = state_q;
    buf_req_o = 1'b0;
    pe_gnt_o  = 1'b0;
    case (state_q)
      TRANS_IDLE:
      begin
        buf_req_o = pe_sel_i;
        if (pe_sel_i && buf_gnt_i)
        begin
          state_d = TRANS_PENDING;  // Request now sits in the buffer
        end
      end
      TRANS_PENDING:
      begin
        if (buf_r_valid_i)
        begin
          state_d = TRANS_GRANTED;
        end
      end
      TRANS_GRANTED:
      begin
        pe_gnt_o = 1'b1;  // Release the core for one cycle
        state_d  = TRANS_IDLE;
      end
      default:
      begin
        state_d = TRANS_IDLE;
      end
    endcase
  end

  // ****************************************
  // Two-stage response delay
  // ****************************************

  always_ff @(posedge clk)
  begin
    if (!rst_ni)
    begin
      rsp_valid_q  <= 1'b0;
      pe_r_valid_o <= 1'b0;
    end
    else
    begin
      rsp_valid_q  <= buf_r_valid_i;
      pe_r_valid_o <= rsp_valid_q;  // One cycle after the core grant
    end
  end

  always_ff @(posedge clk)
  begin
    rsp_rdata_q  <= buf_r_rdata_i;
    rsp_opc_q    <= buf_r_opc_i;
    pe_r_rdata_o <= rsp_rdata_q;
    pe_r_opc_o   <= rsp_opc_q;
  end

  // A PE grant lasts one cycle and the delayed response follows it
  a_gnt_single: assert property (@(posedge clk) disable iff (!rst_ni)
    pe_gnt_o |=> (!pe_gnt_o && pe_r_valid_o));

endmodule

// File: rtl/periph_req_buffer.sv
`timescale 1ns/100ps

module periph_req_buffer #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                              clk,
  input  logic                              rst_ni,
  input  logic                              req_i,
  input  logic [core_demux_pkg::ADDR_W-1:0] addr_i,
  input  logic                              wen_i,
  input  logic [DATA_WIDTH-1:0]             wdata_i,
  input  logic [DATA_WIDTH/8-1:0]           be_i,
  input  logic                              pe_gnt_i,
  input  logic                              pe_r_valid_i,
  input  logic [DATA_WIDTH-1:0]             pe_r_rdata_i,
  input  logic                              pe_r_opc_i,
  output logic                              gnt_o,
  output logic                              pe_req_o,
  output logic [core_demux_pkg::ADDR_W-1:0] pe_addr_o,
  output logic                              pe_wen_o,
  output logic [DATA_WIDTH-1:0]             pe_wdata_o,
  output logic [DATA_WIDTH/8-1:0]           pe_be_o,
  output logic                              r_valid_o,
  output logic [DATA_WIDTH-1:0]             r_rdata_o,
  output logic                              r_opc_o
);

  localparam int BE_W = DATA_WIDTH / 8;

  logic full_q;  // Entry taken until its response returns

  assign gnt_o = req_i & ~full_q;  // Accept only when empty

  // Control state
  always_ff @(posedge clk)
  begin
    if (!rst_ni)
    begin
      full_q   <= 1'b0;
      pe_req_o <= 1'b0;
    end
    else
    begin
      if (gnt_o)
      begin
        full_q   <= 1'b1;
        pe_req_o <= 1'b1;  // Goes out the next cycle
      end
      else
      begin
        if (pe_req_o && pe_gnt_i)
        begin
          pe_req_o <= 1'b0;
        end
        if (full_q && pe_r_valid_i)
        begin
          full_q <= 1'b0;  // Free again from the next cycle
        end
      end
    end
  end

  // Payload register
  always_ff @(posedge clk)
  begin
    if (gnt_o)
    begin
      pe_addr_o  <= addr_i;
      pe_wen_o   <= wen_i;
      pe_wdata_o <= wdata_i;
      pe_be_o    <= be_i[BE_W-1:0];
    end
  end

  // Response goes straight back to the FSM
  assign r_valid_o = pe_r_valid_i & full_q;
  assign r_rdata_o = pe_r_rdata_i;
  assign r_opc_o   = pe_r_opc_i;

  // A waiting PE request keeps its address and data
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_ni)
    (pe_req_o && !pe_gnt_i) |=> ($stable(pe_addr_o) && $stable(pe_wdata_o)));

endmodule

// File: rtl/req_router.sv
`timescale 1ns/100ps

module req_router (
  input  logic                                    core_req_i,
  input  logic [core_demux_pkg::ADDR_W-1:0]       core_addr_i,
  input  logic                                    core_wen_i,   // High for a load
  input  logic [core_demux_pkg::CLUSTER_ID_W-1:0] cluster_id_i,
  input  logic                                    sh_gnt_i,
  input  logic                                    ext_gnt_i,
  input  logic                                    pe_gnt_i,     // From the PE FSM
  output core_demux_pkg::dest_e                   dest_o,
  output logic                                    sh_req_o,
  output logic                                    ext_req_o,
  output logic                                    pe_sel_o,
  output logic                                    core_gnt_o,
  output logic                                    perf_l2_ld_o,
  output logic                                    perf_l2_st_o,
  output logic                                    perf_l2_ld_cyc_o,
  output logic                                    perf_l2_st_cyc_o
);

  localparam int RW = core_demux_pkg::REGION_W;

  logic [RW-1:0] region;      // Region field of the address
  logic [RW-1:0] cluster_off; // Cluster id scaled to four regions
  logic [RW-1:0] region_rw;   // Shared memory, read/write
  logic [RW-1:0] region_ts;   // Shared memory, test-and-set
  logic [RW-1:0] region_per;  // Demux peripherals or PE
  logic          l2_req;      // Request headed to EXT or PE

  // ****************************************
  // Address decode
  // ****************************************

  assign region      = core_addr_i[core_demux_pkg::REGION_MSB:core_demux_pkg::REGION_LSB];
  assign cluster_off = RW'({cluster_id_i, 2'b00});

  assign region_rw  = core_demux_pkg::REGION_BASE + cluster_off;
  assign region_ts  = region_rw + RW'(1);
  assign region_per = region_rw + RW'(2);

  always_comb
  begin
    if ((region == region_rw) || (region == region_ts))
    begin
      dest_o = core_demux_pkg::DEST_SH;
    end
    else if (region == region_per)
    begin
      if (core_addr_i[core_demux_pkg::EXT_SEL_BIT])
      begin
        dest_o = core_demux_pkg::DEST_EXT;  // Demux peripheral half
      end
      else
      begin
        dest_o = core_demux_pkg::DEST_PE;
      end
    end
    else
    begin
      dest_o = core_demux_pkg::DEST_PE;  // Rest of the map
    end
  end

  // ****************************************
  // Request steering and grant select
  // ****************************************

  assign sh_req_o  = core_req_i & (dest_o == core_demux_pkg::DEST_SH);
  assign ext_req_o = core_req_i & (dest_o == core_demux_pkg::DEST_EXT);
  assign pe_sel_o  = core_req_i & (dest_o == core_demux_pkg::DEST_PE);  // FSM decides when

  always_comb
  begin
    case (dest_o)
      core_demux_pkg::DEST_SH:  core_gnt_o = sh_gnt_i;
      core_demux_pkg::DEST_EXT: core_gnt_o = ext_gnt_i;
      core_demux_pkg::DEST_PE:  core_gnt_o = pe_gnt_i;   // One cycle, after the response
      default:                  core_gnt_o = 1'b0;
    endcase
  end

  // Performance strobes for the L2 side
  assign l2_req = sh_req_o ^ core_req_i;  // Any request not to SH

  assign perf_l2_ld_o     = l2_req & core_gnt_o & core_wen_i;
  assign perf_l2_st_o     = l2_req & core_gnt_o & ~core_wen_i;
  assign perf_l2_ld_cyc_o = l2_req & core_wen_i;   // Every cycle a load waits
  assign perf_l2_st_cyc_o = l2_req & ~core_wen_i;

endmodule

// File: rtl/resp_router.sv
`timescale 1ns/100ps

module resp_router #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  logic                  core_req_i,
  input  core_demux_pkg::dest_e dest_i,
  input  logic                  sh_r_valid_i,
  input  logic [DATA_WIDTH-1:0] sh_r_rdata_i,
  input  logic                  ext_r_valid_i,
  input  logic [DATA_WIDTH-1:0] ext_r_rdata_i,
  input  logic                  ext_r_opc_i,
  input  logic                  pe_r_valid_i,   // Already delayed two cycles
  input  logic [DATA_WIDTH-1:0] pe_r_rdata_i,
  input  logic                  pe_r_opc_i,
  output logic                  core_r_valid_o,
  output logic [DATA_WIDTH-1:0] core_r_rdata_o,
  output logic                  core_r_opc_o
);

  core_demux_pkg::dest_e dest_q;  // Target of the last request

  always_ff @(posedge clk)
  begin
    if (!rst_ni)
    begin
      dest_q <= core_demux_pkg::DEST_SH;
    end
    else if (core_req_i)
    begin
      dest_q <= dest_i;  // Sampled on every requesting cycle
    end
  end

  // Response mux
  always_comb
  begin
    core_r_valid_o = 1'b0;
    core_r_rdata_o = '0;
    core_r_opc_o   = 1'b0;
    case (dest_q)
      core_demux_pkg::DEST_SH:
      begin
        core_r_valid_o = sh_r_valid_i;
        core_r_rdata_o = sh_r_rdata_i;  // SH never reports errors
      end
      core_demux_pkg::DEST_EXT:
      begin
        core_r_valid_o = ext_r_valid_i;
        core_r_rdata_o = ext_r_rdata_i;
        core_r_opc_o   = ext_r_opc_i;
      end
      core_demux_pkg::DEST_PE:
      begin
        core_r_valid_o = pe_r_valid_i;
        core_r_rdata_o = pe_r_rdata_i;
        core_r_opc_o   = pe_r_opc_i;
      end
      default:
      begin
        core_r_valid_o = 1'b0;
      end
    endcase
  end

  // A shared-memory response reaches the core without an error flag
  a_sh_no_error: assert property (@(posedge clk) disable iff (!rst_ni)
    sh_r_valid_i |-> (core_r_valid_o && !core_r_opc_o));

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f project.f \
  --top-module core_demux_tb -o core_demux_sim

./obj_dir/core_demux_sim | tee sim.log

if grep -qx "STATUS: PASS" sim.log
then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
